/* hw/rv_lsu_pkg.sv */
package rv_lsu_pkg;

  // register and bus data width
  localparam int data_width = 32;

  // major opcodes
  localparam logic [6:0] opcode_load  = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;

  // funct3 access codes
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  // one instruction word, read as I-type for loads or S-type for stores
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_type;
    struct packed {
      logic [6:0]  imm_hi;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
    } s_type;
  } rv_instr_t;

endpackage

/* hw/axil_mem_pkg.sv */
package axil_mem_pkg;

  localparam int addr_width = 32;
  localparam int strb_width = 4;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // word interleaved banks
  localparam int num_banks       = 4;
  localparam int bank_sel_width  = 2;
  localparam int bank_depth      = 64;
  localparam int bank_addr_width = 6;
  localparam int mem_bytes       = 1024;

  // address split: [3:2] bank, [9:4] row
  localparam int bank_sel_lsb = 2;
  localparam int row_lsb      = 4;

endpackage

/* hw/mem_bank.sv */
`timescale 1ns/1ps
module mem_bank (
  input  logic                                     clock,
  input  logic                                     en_i,
  input  logic                                     we_i,
  input  logic [axil_mem_pkg::bank_addr_width-1:0] row_i,
  input  logic [rv_lsu_pkg::data_width-1:0]        wdata_i,
  input  logic [axil_mem_pkg::strb_width-1:0]      wstrb_i,
  output logic [rv_lsu_pkg::data_width-1:0]        rdata_o
);
  import rv_lsu_pkg::*;
  import axil_mem_pkg::*;

  logic [data_width-1:0] mem [bank_depth];
  logic [data_width-1:0] rdata_q;

  always_ff @(posedge clock) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < strb_width; b++) begin
          if (wstrb_i[b]) begin
            mem[row_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        // registered read, one cycle after en
        rdata_q <= mem[row_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* hw/mem_bank_router.sv */
`timescale 1ns/1ps
module mem_bank_router (
  input  logic                                     clock,
  input  logic                                     reset,
  input  logic                                     awvalid_i,
  input  logic [axil_mem_pkg::addr_width-1:0]      awaddr_i,
  input  logic                                     wvalid_i,
  input  logic [rv_lsu_pkg::data_width-1:0]        wdata_i,
  input  logic [axil_mem_pkg::strb_width-1:0]      wstrb_i,
  input  logic                                     bready_i,
  input  logic                                     arvalid_i,
  input  logic [axil_mem_pkg::addr_width-1:0]      araddr_i,
  output logic                                     awready_o,
  output logic                                     wready_o,
  output logic                                     bvalid_o,
  output logic [1:0]                               bresp_o,
  output logic                                     arready_o,
  output logic [axil_mem_pkg::num_banks-1:0]       bank_en_o,
  output logic                                     bank_we_o,
  output logic [axil_mem_pkg::bank_addr_width-1:0] bank_row_o,
  output logic [rv_lsu_pkg::data_width-1:0]        bank_wdata_o,
  output logic [axil_mem_pkg::strb_width-1:0]      bank_wstrb_o,
  output logic                                     rd_capture_o,
  output logic [axil_mem_pkg::bank_sel_width-1:0]  rd_sel_o,
  output logic                                     rd_err_o,
  input  logic                                     r_busy_i
);
  import axil_mem_pkg::*;

  logic                      accept_w, accept_r, in_range;
  logic [addr_width-1:0]     addr;
  logic [bank_sel_width-1:0] sel;
  logic                      bvalid_q;
  logic [1:0]                bresp_q;

  // AW and W only together, and only with the B slot free
  assign accept_w = awvalid_i && wvalid_i && !bvalid_q;
  // writes win if both sides show up
  assign accept_r = arvalid_i && !r_busy_i && !accept_w;

  assign addr     = accept_w ? awaddr_i : araddr_i;
  assign sel      = addr[bank_sel_lsb +: bank_sel_width];
  assign in_range = addr < addr_width'(mem_bytes);

  assign bank_en_o    = ((accept_w || accept_r) && in_range) ? (num_banks'(1) << sel) : '0;
  assign bank_we_o    = accept_w;
  assign bank_row_o   = addr[row_lsb +: bank_addr_width];
  assign bank_wdata_o = wdata_i;
  assign bank_wstrb_o = wstrb_i;

  assign awready_o = accept_w;
  assign wready_o  = accept_w;
  assign arready_o = accept_r;

  assign rd_capture_o = accept_r;
  assign rd_sel_o     = sel;
  assign rd_err_o     = !in_range;

  always_ff @(posedge clock) begin
    if (reset) begin
      bvalid_q <= 1'b0;
    end else if (accept_w) begin
      bvalid_q <= 1'b1;
    end else if (bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept_w) begin
      bresp_q <= in_range ? resp_okay : resp_slverr;
    end
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;

endmodule

/* hw/mem_read_merge.sv */
`timescale 1ns/1ps
module mem_read_merge (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    rd_capture_i,
  input  logic [axil_mem_pkg::bank_sel_width-1:0] rd_sel_i,
  input  logic                                    rd_err_i,
  input  logic [rv_lsu_pkg::data_width-1:0]       bank_rdata_i [axil_mem_pkg::num_banks],
  output logic                                    rvalid_o,
  output logic [rv_lsu_pkg::data_width-1:0]       rdata_o,
  output logic [1:0]                              rresp_o,
  input  logic                                    rready_i,
  output logic                                    r_busy_o
);
  import rv_lsu_pkg::*;
  import axil_mem_pkg::*;

  logic                      cap_q, err_q, rvalid_q;
  logic [bank_sel_width-1:0] sel_q;
  logic [data_width-1:0]     rdata_q;
  logic [1:0]                rresp_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      cap_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      cap_q <= rd_capture_i;
      if (cap_q) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // sel and err wait one cycle for the bank data
  always_ff @(posedge clock) begin
    sel_q <= rd_sel_i;
    err_q <= rd_err_i;
    if (cap_q) begin
      rdata_q <= err_q ? '0 : bank_rdata_i[sel_q];
      rresp_q <= err_q ? resp_slverr : resp_okay;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;
  // pending from the capture cycle until the beat leaves
  assign r_busy_o = cap_q || rvalid_q;

endmodule

/* hw/load_store_unit.sv */
`timescale 1ns/1ps
module load_store_unit (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                start_i,
  input  rv_lsu_pkg::rv_instr_t               instr_i,
  input  logic [rv_lsu_pkg::data_width-1:0]   rs1_i,
  input  logic [rv_lsu_pkg::data_width-1:0]   rs2_i,
  output logic                                awvalid_o,
  output logic [axil_mem_pkg::addr_width-1:0] awaddr_o,
  output logic                                wvalid_o,
  output logic [rv_lsu_pkg::data_width-1:0]   wdata_o,
  output logic [axil_mem_pkg::strb_width-1:0] wstrb_o,
  output logic                                bready_o,
  output logic                                arvalid_o,
  output logic [axil_mem_pkg::addr_width-1:0] araddr_o,
  output logic                                rready_o,
  input  logic                                awready_i,
  input  logic                                wready_i,
  input  logic                                bvalid_i,
  input  logic [1:0]                          bresp_i,
  input  logic                                arready_i,
  input  logic                                rvalid_i,
  input  logic [rv_lsu_pkg::data_width-1:0]   rdata_i,
  input  logic [1:0]                          rresp_i,
  output logic                                busy_o,
  output logic                                done_o,
  output logic                                load_o,
  output logic [rv_lsu_pkg::data_width-1:0]   result_o,
  output logic                                misalign_o,
  output logic                                bus_err_o
);
  import rv_lsu_pkg::*;
  import axil_mem_pkg::*;

  logic                  busy_q, done_q, load_q, misalign_q, bus_err_q;
  logic                  awvalid_q, wvalid_q, arvalid_q;
  rv_instr_t             instr_q;
  logic [addr_width-1:0] addr_q;
  logic [data_width-1:0] wdata_q, result_q;
  logic [strb_width-1:0] wstrb_q;

  logic                  issue, is_load, is_store, misaligned;
  logic [2:0]            funct3;
  logic [data_width-1:0] imm, rdata_sh, load_val;
  logic [addr_width-1:0] eff_addr;
  logic [strb_width-1:0] wstrb_d;

  assign issue    = start_i && !busy_q;
  assign is_load  = instr_i.i_type.opcode == opcode_load;
  assign is_store = instr_i.s_type.opcode == opcode_store;
  // funct3 sits in the same bits in both views
  assign funct3   = instr_i.i_type.funct3;

  assign imm = is_store ?
      {{(data_width-12){instr_i.s_type.imm_hi[6]}}, instr_i.s_type.imm_hi,
       instr_i.s_type.imm_lo} :
      {{(data_width-12){instr_i.i_type.imm[11]}}, instr_i.i_type.imm};
  assign eff_addr = rs1_i + imm;

  always_comb begin
    case (funct3)
      f3_half, f3_half_u: misaligned = eff_addr[0];
      f3_word:            misaligned = eff_addr[1:0] != 2'b00;
      default:            misaligned = 1'b0;
    endcase
  end

  always_comb begin
    case (funct3)
      f3_byte: wstrb_d = 4'b0001 << eff_addr[1:0];
      f3_half: wstrb_d = 4'b0011 << eff_addr[1:0];
      default: wstrb_d = 4'b1111;
    endcase
  end

  // pick the addressed lane, then extend by funct3
  assign rdata_sh = rdata_i >> {addr_q[1:0], 3'b000};

  always_comb begin
    case (instr_q.i_type.funct3)
      f3_byte:   load_val = {{(data_width-8){rdata_sh[7]}}, rdata_sh[7:0]};
      f3_half:   load_val = {{(data_width-16){rdata_sh[15]}}, rdata_sh[15:0]};
      f3_byte_u: load_val = {{(data_width-8){1'b0}}, rdata_sh[7:0]};
      f3_half_u: load_val = {{(data_width-16){1'b0}}, rdata_sh[15:0]};
      default:   load_val = rdata_sh;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      load_q     <= 1'b0;
      misalign_q <= 1'b0;
      bus_err_q  <= 1'b0;
      awvalid_q  <= 1'b0;
      wvalid_q   <= 1'b0;
      arvalid_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (issue) begin
        busy_q     <= 1'b1;
        load_q     <= is_load;
        misalign_q <= misaligned;
        bus_err_q  <= 1'b0;
        // misaligned requests finish at once, no bus traffic
        done_q     <= misaligned;
        awvalid_q  <= !misaligned && is_store;
        wvalid_q   <= !misaligned && is_store;
        arvalid_q  <= !misaligned && !is_store;
      end else if (done_q) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        if (awready_i) begin
          awvalid_q <= 1'b0;
        end
        if (wready_i) begin
          wvalid_q <= 1'b0;
        end
        if (arready_i) begin
          arvalid_q <= 1'b0;
        end
        if (bvalid_i || rvalid_i) begin
          done_q    <= 1'b1;
          bus_err_q <= (bvalid_i && bresp_i == resp_slverr) ||
                       (rvalid_i && rresp_i == resp_slverr);
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      instr_q  <= instr_i;
      addr_q   <= eff_addr;
      wdata_q  <= rs2_i << {eff_addr[1:0], 3'b000};
      wstrb_q  <= wstrb_d;
      result_q <= '0;
    end else if (busy_q && !done_q && rvalid_i) begin
      result_q <= (rresp_i == resp_slverr) ? '0 : load_val;
    end
  end

  assign awvalid_o  = awvalid_q;
  assign awaddr_o   = {addr_q[addr_width-1:2], 2'b00};
  assign wvalid_o   = wvalid_q;
  assign wdata_o    = wdata_q;
  assign wstrb_o    = wstrb_q;
  assign arvalid_o  = arvalid_q;
  assign araddr_o   = {addr_q[addr_width-1:2], 2'b00};
  // responses are never stalled
  assign bready_o   = 1'b1;
  assign rready_o   = 1'b1;

  assign busy_o     = busy_q;
  assign done_o     = done_q;
  assign load_o     = load_q;
  assign result_o   = result_q;
  assign misalign_o = misalign_q;
  assign bus_err_o  = bus_err_q;

endmodule

/* hw/lsu_mem_top.sv */
`timescale 1ns/1ps
module lsu_mem_top (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              start_i,
  input  rv_lsu_pkg::rv_instr_t             instr_i,
  input  logic [rv_lsu_pkg::data_width-1:0] rs1_i,
  input  logic [rv_lsu_pkg::data_width-1:0] rs2_i,
  output logic                              busy_o,
  output logic                              done_o,
  output logic                              load_o,
  output logic [rv_lsu_pkg::data_width-1:0] result_o,
  output logic                              misalign_o,
  output logic                              bus_err_o
);
  import rv_lsu_pkg::*;
  import axil_mem_pkg::*;

  logic                       awvalid, awready, wvalid, wready, bvalid, bready;
  logic                       arvalid, arready, rvalid, rready;
  logic [addr_width-1:0]      awaddr, araddr;
  logic [data_width-1:0]      wdata, rdata;
  logic [strb_width-1:0]      wstrb;
  logic [1:0]                 bresp, rresp;

  logic [num_banks-1:0]       bank_en;
  logic                       bank_we;
  logic [bank_addr_width-1:0] bank_row;
  logic [data_width-1:0]      bank_wdata;
  logic [strb_width-1:0]      bank_wstrb;
  logic [data_width-1:0]      bank_rdata [num_banks];
  logic                       rd_capture, rd_err, r_busy;
  logic [bank_sel_width-1:0]  rd_sel;

  load_store_unit u_lsu (
    .clock(clock), .reset(reset), .start_i(start_i), .instr_i(instr_i),
    .rs1_i(rs1_i), .rs2_i(rs2_i),
    .awvalid_o(awvalid), .awaddr_o(awaddr), .wvalid_o(wvalid), .wdata_o(wdata),
    .wstrb_o(wstrb), .bready_o(bready), .arvalid_o(arvalid), .araddr_o(araddr),
    .rready_o(rready), .awready_i(awready), .wready_i(wready), .bvalid_i(bvalid),
    .bresp_i(bresp), .arready_i(arready), .rvalid_i(rvalid), .rdata_i(rdata),
    .rresp_i(rresp), .busy_o(busy_o), .done_o(done_o), .load_o(load_o),
    .result_o(result_o), .misalign_o(misalign_o), .bus_err_o(bus_err_o)
  );

  mem_bank_router u_router (
    .clock(clock), .reset(reset),
    .awvalid_i(awvalid), .awaddr_i(awaddr), .wvalid_i(wvalid), .wdata_i(wdata),
    .wstrb_i(wstrb), .bready_i(bready), .arvalid_i(arvalid), .araddr_i(araddr),
    .awready_o(awready), .wready_o(wready), .bvalid_o(bvalid), .bresp_o(bresp),
    .arready_o(arready), .bank_en_o(bank_en), .bank_we_o(bank_we),
    .bank_row_o(bank_row), .bank_wdata_o(bank_wdata), .bank_wstrb_o(bank_wstrb),
    .rd_capture_o(rd_capture), .rd_sel_o(rd_sel), .rd_err_o(rd_err), .r_busy_i(r_busy)
  );

  for (genvar g = 0; g < num_banks; g++) begin : g_bank
    mem_bank u_bank (
      .clock(clock), .en_i(bank_en[g]), .we_i(bank_we), .row_i(bank_row),
      .wdata_i(bank_wdata), .wstrb_i(bank_wstrb), .rdata_o(bank_rdata[g])
    );
  end

  mem_read_merge u_merge (
    .clock(clock), .reset(reset), .rd_capture_i(rd_capture), .rd_sel_i(rd_sel),
    .rd_err_i(rd_err), .bank_rdata_i(bank_rdata), .rvalid_o(rvalid), .rdata_o(rdata),
    .rresp_o(rresp), .rready_i(rready), .r_busy_o(r_busy)
  );

endmodule

/* sim/lsu_mem_sva.sv */
`timescale 1ns/1ps
module lsu_mem_sva (
  input logic                                clock,
  input logic                                reset,
  input logic                                awvalid_i,
  input logic                                awready_i,
  input logic [axil_mem_pkg::addr_width-1:0] awaddr_i,
  input logic                                wvalid_i,
  input logic                                wready_i,
  input logic [rv_lsu_pkg::data_width-1:0]   wdata_i,
  input logic [axil_mem_pkg::strb_width-1:0] wstrb_i,
  input logic                                arvalid_i,
  input logic                                arready_i,
  input logic [axil_mem_pkg::addr_width-1:0] araddr_i,
  input logic                                busy_i,
  input logic                                done_i,
  input logic                                misalign_i
);

  // valids hold with a stable payload until ready
  aw_hold: assert property (@(posedge clock) disable iff (reset)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
    else $error("awvalid or awaddr changed before awready");
  w_hold: assert property (@(posedge clock) disable iff (reset)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
    else $error("wvalid, wdata or wstrb changed before wready");
  ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else $error("arvalid or araddr changed before arready");

  one_cmd: assert property (@(posedge clock) disable iff (reset)
    !(arvalid_i && awvalid_i))
    else $error("arvalid and awvalid high together");

  done_pulse: assert property (@(posedge clock) disable iff (reset)
    done_i |=> !done_i)
    else $error("done_o held longer than one cycle");
  done_busy: assert property (@(posedge clock) disable iff (reset)
    done_i |-> busy_i)
    else $error("done_o raised while busy_o low");

  // a misaligned request never reaches the bus
  misalign_quiet: assert property (@(posedge clock) disable iff (reset)
    misalign_i |-> !arvalid_i && !awvalid_i && !wvalid_i)
    else $error("bus valid raised for a misaligned request");

endmodule

bind lsu_mem_top lsu_mem_sva u_sva (
  .clock(clock), .reset(reset),
  .awvalid_i(awvalid), .awready_i(awready), .awaddr_i(awaddr),
  .wvalid_i(wvalid), .wready_i(wready), .wdata_i(wdata), .wstrb_i(wstrb),
  .arvalid_i(arvalid), .arready_i(arready), .araddr_i(araddr),
  .busy_i(busy_o), .done_i(done_o), .misalign_i(misalign_o)
);

/* sim/tb_lsu_mem.sv */
`timescale 1ns/1ps
module tb_lsu_mem;
  import rv_lsu_pkg::*;
  import axil_mem_pkg::*;

  localparam int init_ops     = 256;
  localparam int directed_ops = 84;
  localparam int rand_ops     = 200;
  localparam int max_cycles   = (init_ops + directed_ops + rand_ops) * 8 + 100;

  logic                  clock = 1'b0;
  logic                  reset;
  logic                  start_i;
  rv_instr_t             instr_i;
  logic [data_width-1:0] rs1_i, rs2_i;
  logic                  busy_o, done_o, load_o, misalign_o, bus_err_o;
  logic [data_width-1:0] result_o;

  logic [7:0]            ref_mem [mem_bytes];
  logic [num_banks-1:0]  bank_hit;
  logic [31:0]           seed;
  int                    cycles = 0;
  logic [2:0]            load_codes [5];
  logic [2:0]            store_codes [3];

  lsu_mem_top u_dut (
    .clock(clock), .reset(reset), .start_i(start_i), .instr_i(instr_i),
    .rs1_i(rs1_i), .rs2_i(rs2_i), .busy_o(busy_o), .done_o(done_o),
    .load_o(load_o), .result_o(result_o), .misalign_o(misalign_o),
    .bus_err_o(bus_err_o)
  );

  always #4 clock = ~clock;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    // high half of the state is the better mixed one
    return {seed[15:0], seed[31:16]};
  endfunction

  // little endian read of the reference bytes
  function automatic logic [31:0] model_load(input logic [2:0] f3, input int idx);
    case (f3)
      f3_byte:   return {{24{ref_mem[idx][7]}}, ref_mem[idx]};
      f3_byte_u: return {24'd0, ref_mem[idx]};
      f3_half:   return {{16{ref_mem[idx+1][7]}}, ref_mem[idx+1], ref_mem[idx]};
      f3_half_u: return {16'd0, ref_mem[idx+1], ref_mem[idx]};
      default:   return {ref_mem[idx+3], ref_mem[idx+2], ref_mem[idx+1], ref_mem[idx]};
    endcase
  endfunction

  task automatic stop_run();
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic run_op(input logic st, input logic [2:0] f3, input logic [31:0] base,
                        input logic [11:0] imm, input logic [31:0] data);
    rv_instr_t   instr;
    logic [31:0] addr, exp_res;
    logic        mis, oor;
    int          idx, nbytes;
    addr   = base + {{20{imm[11]}}, imm};
    nbytes = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
    mis    = (nbytes == 2 && addr[0]) || (nbytes == 4 && addr[1:0] != 2'b00);
    oor    = addr >= 32'(mem_bytes);
    idx    = int'(addr[9:0]);
    exp_res = '0;
    if (!mis && !oor) begin
      bank_hit[addr[3:2]] = 1'b1;
      if (st) begin
        for (int i = 0; i < nbytes; i++) begin
          ref_mem[idx+i] = data[8*i +: 8];
        end
      end else begin
        exp_res = model_load(f3, idx);
      end
    end
    instr = '0;
    if (st) begin
      instr.s_type.imm_hi = imm[11:5];
      instr.s_type.rs2    = 5'd2;
      instr.s_type.rs1    = 5'd1;
      instr.s_type.funct3 = f3;
      instr.s_type.imm_lo = imm[4:0];
      instr.s_type.opcode = opcode_store;
    end else begin
      instr.i_type.imm    = imm;
      instr.i_type.rs1    = 5'd1;
      instr.i_type.funct3 = f3;
      instr.i_type.rd     = 5'd3;
      instr.i_type.opcode = opcode_load;
    end
    @(posedge clock);
    #1;
    check_val("busy_o", 32'd0, 32'(busy_o));
    start_i = 1'b1;
    instr_i = instr;
    rs1_i   = base;
    rs2_i   = data;
    @(posedge clock);
    #1;
    start_i = 1'b0;
    check_val("busy_o", 32'd1, 32'(busy_o));
    // misaligned requests finish right away
    if (mis) begin
      check_val("done_o", 32'd1, 32'(done_o));
    end
    while (!done_o) begin
      @(posedge clock);
      #1;
    end
    check_val("misalign_o", 32'(mis), 32'(misalign_o));
    check_val("bus_err_o", 32'(!mis && oor), 32'(bus_err_o));
    check_val("load_o", 32'(!st), 32'(load_o));
    check_val("result_o", exp_res, result_o);
  endtask

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      stop_run();
    end
  end

  initial begin
    logic [31:0] r, data, target, mask, word;
    logic [11:0] imm;
    logic        st;
    logic [2:0]  f3;
    seed     = 32'd19929;
    bank_hit = '0;
    load_codes  = '{f3_byte, f3_half, f3_word, f3_byte_u, f3_half_u};
    store_codes = '{f3_byte, f3_half, f3_word};
    reset   = 1'b1;
    start_i = 1'b0;
    instr_i = '0;
    rs1_i   = '0;
    rs2_i   = '0;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;

    // fill the whole memory so every later load has a known value
    for (int w = 0; w < init_ops; w++) begin
      run_op(1'b1, f3_word, 32'(w * 4), 12'd0, lcg_next());
    end

    // store a word, then read it back in every width, one word per bank
    for (int k = 0; k < 4; k++) begin
      word = (k == 0) ? 32'h010 : (k == 1) ? 32'h0a4 : (k == 2) ? 32'h1f8 : 32'h3fc;
      data = k[0] ? (lcg_next() & 32'h7f7f7f7f) : (lcg_next() | 32'h80008000);
      run_op(1'b1, f3_word, word, 12'd0, data);
      for (int off = 0; off < 4; off++) begin
        // negative immediate against a raised base
        run_op(1'b0, f3_byte, word + 32'h40, 12'(off - 64), 32'd0);
        run_op(1'b0, f3_byte_u, word + 32'h40, 12'(off - 64), 32'd0);
      end
      for (int off = 0; off < 4; off += 2) begin
        run_op(1'b0, f3_half, word, 12'(off), 32'd0);
        run_op(1'b0, f3_half_u, word, 12'(off), 32'd0);
      end
      run_op(1'b0, f3_word, word, 12'd0, 32'd0);
    end

    // byte and half stores leave the rest of the word alone
    for (int b = 0; b < 4; b++) begin
      word = 32'h200 + 32'(b * 4);
      run_op(1'b1, f3_byte, word, 12'(b), lcg_next());
      run_op(1'b0, f3_word, word, 12'd0, 32'd0);
      run_op(1'b1, f3_half, word, b[0] ? 12'd2 : 12'd0, lcg_next());
      run_op(1'b0, f3_word, word, 12'd0, 32'd0);
    end

    // misaligned requests
    run_op(1'b0, f3_half, 32'h300, 12'd1, 32'd0);
    run_op(1'b0, f3_word, 32'h300, 12'd2, 32'd0);
    run_op(1'b1, f3_half, 32'h300, 12'd3, 32'hdead_beef);
    run_op(1'b1, f3_word, 32'h300, 12'd1, 32'hcafe_f00d);
    run_op(1'b0, f3_word, 32'h300, 12'd0, 32'd0);

    // stores past the end of memory must not alias low words
    run_op(1'b1, f3_word, 32'h400, 12'd0, 32'h1234_5678);
    run_op(1'b0, f3_word, 32'h400, 12'd0, 32'd0);
    run_op(1'b0, f3_byte, 32'h7d0, 12'd0, 32'd0);
    run_op(1'b1, f3_byte, 32'h404, 12'd0, 32'h0000_00a5);
    run_op(1'b0, f3_half, 32'hffff_fff0, 12'd0, 32'd0);
    run_op(1'b0, f3_word, 32'h000, 12'd0, 32'd0);
    run_op(1'b0, f3_word, 32'h004, 12'd0, 32'd0);

    bank_hit = '0;
    for (int n = 0; n < rand_ops; n++) begin
      r      = lcg_next();
      st     = r[0];
      f3     = st ? store_codes[int'(r[2:1] % 2'd3)] : load_codes[int'(r[5:3] % 3'd5)];
      target = lcg_next() % 32'd1100;
      mask   = (f3[1:0] == 2'b10) ? 32'd3 : (f3[1:0] == 2'b01) ? 32'd1 : 32'd0;
      // a quarter of the targets keep their drawn alignment
      if (r[7:6] != 2'b00) begin
        target = target & ~mask;
      end
      imm  = 12'(lcg_next() >> 20);
      data = lcg_next();
      run_op(st, f3, target - {{20{imm[11]}}, imm}, imm, data);
    end
    for (int b = 0; b < num_banks; b++) begin
      assert (bank_hit[b]) else begin
        $display("random sequence never reached bank %0d", b);
        stop_run();
      end
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* lsu_mem.f */
hw/rv_lsu_pkg.sv
hw/axil_mem_pkg.sv
hw/mem_bank.sv
hw/mem_bank_router.sv
hw/mem_read_merge.sv
hw/load_store_unit.sv
hw/lsu_mem_top.sv
sim/lsu_mem_sva.sv
sim/tb_lsu_mem.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_lsu_mem
FILELIST = lsu_mem.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = STATUS: FAIL
PASS_MSG = STATUS: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD) $(LOG)
